/* project.f */
src/cpu_pkg.sv
src/debug_pkg.sv
src/reg_port_if.sv
src/inst_mem.sv
src/reg_file.sv
src/alu.sv
src/core_ctrl.sv
src/led_ctrl.sv
src/cpu_top.sv
sim/cpu_top_chk.sv
sim/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_top \
	-f project.f --Mdir obj_dir -o sim_cpu_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_cpu_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "No result line found in sim.log"
	exit 1
fi
exit 0

/* sim/tb_cpu_top.sv */
module tb_cpu_top import cpu_pkg::*, debug_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PROGS  = 6;
	localparam int MAX_PULSES = 5;
	localparam int HALT_LIMIT = 4 * 41 + 20;
	// Per program budget plus the reset and view checks at either end
	localparam int WATCHDOG_CYCLES = NUM_PROGS * (256 + 4 * 41 + 60) + 100;

	logic               clk;
	logic               reset;
	logic               boot_done;
	logic               hold;
	logic               init_mem_wr;
	logic [IMEM_AW-1:0] init_addr;
	logic [DATA_W-1:0]  init_data;
	logic [LED_W-1:0]   sw;
	logic [LED_W-1:0]   led_data;

	logic [31:0]        rng;
	int                 value_errors;
	int                 other_errors;
	int                 prog_len;
	logic [DATA_W-1:0]  prog [IMEM_DEPTH];
	logic [DATA_W-1:0]  model_regs [NUM_REGS];
	logic               exp_writes [IMEM_DEPTH];
	logic [REG_AW-1:0]  exp_dest [IMEM_DEPTH];
	logic [DATA_W-1:0]  exp_res [IMEM_DEPTH];

	cpu_top DUT (
		.clk         (clk),
		.reset       (reset),
		.boot_done   (boot_done),
		.hold        (hold),
		.init_mem_wr (init_mem_wr),
		.init_addr   (init_addr),
		.init_data   (init_data),
		.sw          (sw),
		.led_data    (led_data)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Random programs and reference model
	//////////////////////////////////////////////////////////////////////
	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [DATA_W-1:0] make_inst(input logic [31:0] r);
		opcode_e opc;
		case (r[2:0])
			3'd0:    opc = LI;
			3'd1:    opc = ADDIU;
			3'd2:    opc = ADDU;
			3'd3:    opc = SUBU;
			3'd4:    opc = AND_OP;
			3'd5:    opc = OR_OP;
			3'd6:    opc = SLL;
			default: opc = NOP;
		endcase
		return {opc, r[18:8]};
	endfunction

	task automatic build_program();
		prog_len = 9 + int'(next_rand() % 32'd33);
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			if (i < prog_len - 1) begin
				prog[i] = make_inst(next_rand());
			end else if (i == prog_len - 1) begin
				prog[i] = {HALT, 11'd0};
			end else begin
				prog[i] = {NOP, 11'd0};
			end
		end
	endtask

	task automatic run_model();
		opcode_e           opc;
		logic [REG_AW-1:0] rx;
		logic [REG_AW-1:0] ry;
		logic [REG_AW-1:0] rz;
		logic [7:0]        imm;
		int                sh;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		for (int k = 0; k < prog_len - 1; k++) begin
			opc = opcode_e'(prog[k][15:11]);
			rx  = prog[k][10:8];
			ry  = prog[k][7:5];
			rz  = prog[k][4:2];
			imm = prog[k][7:0];
			sh  = (rz == 3'd0) ? 8 : int'(rz);
			exp_writes[k] = 1'b1;
			exp_dest[k]   = rx;
			case (opc)
				LI:      exp_res[k] = {8'h00, imm};
				ADDIU:   exp_res[k] = model_regs[rx] + {{8{imm[7]}}, imm};
				SLL:     exp_res[k] = model_regs[rx] << sh;
				ADDU:    exp_res[k] = model_regs[rx] + model_regs[ry];
				SUBU:    exp_res[k] = model_regs[rx] - model_regs[ry];
				AND_OP:  exp_res[k] = model_regs[rx] & model_regs[ry];
				OR_OP:   exp_res[k] = model_regs[rx] | model_regs[ry];
				default: begin
					exp_writes[k] = 1'b0;
					exp_res[k]    = '0;
				end
			endcase
			// Three register ops land in rz
			if (opc inside {ADDU, SUBU, AND_OP, OR_OP}) begin
				exp_dest[k] = rz;
			end
			if (exp_writes[k]) begin
				model_regs[exp_dest[k]] = exp_res[k];
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and view access
	//////////////////////////////////////////////////////////////////////
	task automatic check_data(input string what, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_status(input string what, input logic [LED_W-1:0] got,
			input logic boot_b, input logic hold_b, input logic halt_b, input logic run_b);
		logic [LED_W-1:0] exp;
		exp              = '0;
		exp[STAT_BOOT]   = boot_b;
		exp[STAT_HOLD]   = hold_b;
		exp[STAT_HALTED] = halt_b;
		exp[STAT_RUN]    = run_b;
		if (got !== exp) begin
			$display("FAILED %s led_data: got %h, expected %h", what, got, exp);
			value_errors++;
		end
	endtask

	function automatic logic [LED_W-1:0] reg_view(input int idx);
		return VIEW_REG_BASE + LED_W'(idx);
	endfunction

	// Switch on the next rising edge, sample mid cycle
	task automatic read_view(input logic [LED_W-1:0] view, output logic [LED_W-1:0] value);
		@(posedge clk);
		sw <= view;
		@(negedge clk);
		value = led_data;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset     <= 1'b1;
		boot_done <= 1'b0;
		hold      <= 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic check_after_reset();
		logic [LED_W-1:0] v;
		read_view(VIEW_STATUS, v);
		check_status("status after reset", v, 1'b0, 1'b0, 1'b0, 1'b0);
		read_view(VIEW_PC, v);
		check_data("led_data pc after reset", v, '0);
		for (int r = 0; r < NUM_REGS; r++) begin
			read_view(reg_view(r), v);
			check_data($sformatf("led_data r%0d after reset", r), v, '0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Program load, one write per cycle
	//////////////////////////////////////////////////////////////////////
	task automatic check_init(input int idx);
		if (idx[0]) begin
			check_data($sformatf("led_data init data %0d", idx), led_data, prog[idx]);
		end else begin
			check_data($sformatf("led_data init addr %0d", idx), led_data,
				{8'h00, idx[7:0]});
		end
	endtask

	task automatic load_program();
		for (int a = 0; a <= IMEM_DEPTH; a++) begin
			@(posedge clk);
			init_mem_wr <= (a < IMEM_DEPTH);
			init_addr   <= a[7:0];
			init_data   <= prog[a % IMEM_DEPTH];
			// Look at the write that lands on this edge
			sw <= a[0] ? VIEW_INIT_ADDR : VIEW_INIT_DATA;
			@(negedge clk);
			if (a > 0) begin
				check_init(a - 1);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Runs
	//////////////////////////////////////////////////////////////////////
	task automatic wait_halted();
		logic [LED_W-1:0] v;
		int               n;
		v = '0;
		n = 0;
		while (!v[STAT_HALTED] && n < HALT_LIMIT) begin
			read_view(VIEW_STATUS, v);
			n++;
		end
		if (!v[STAT_HALTED]) begin
			$display("Core did not reach HALT within %0d cycles", HALT_LIMIT);
			other_errors++;
		end else begin
			check_status("status at halt", v, 1'b1, 1'b0, 1'b1, 1'b0);
		end
	endtask

	// Instruction k enters WRITEBACK on edge 4 * (k + 1)
	// and completes it on edge 1 + 4 * (k + 1)
	task automatic run_timed();
		logic [LED_W-1:0] v;
		int               pos;
		@(posedge clk);
		boot_done <= 1'b1;
		pos = 0;
		for (int k = 0; k < prog_len - 1; k++) begin
			if (exp_writes[k]) begin
				while (pos < 4 * k + 3) begin
					@(posedge clk);
					pos++;
				end
				read_view(VIEW_ALU_RES, v);
				check_data($sformatf("led_data alu_res inst %0d", k), v, exp_res[k]);
				read_view(VIEW_WB_RES, v);
				check_data($sformatf("led_data wb_res inst %0d", k), v, exp_res[k]);
				read_view(reg_view(int'(exp_dest[k])), v);
				check_data($sformatf("led_data r%0d inst %0d", exp_dest[k], k), v,
					exp_res[k]);
				pos += 3;
			end
		end
		wait_halted();
	endtask

	task automatic run_with_hold();
		logic [LED_W-1:0] v;
		logic [LED_W-1:0] pc_ref;
		logic [LED_W-1:0] st_ref;
		logic             have_st;
		logic             done;
		int               pulses;
		int               gap;
		int               len;
		@(posedge clk);
		boot_done <= 1'b1;
		done   = 1'b0;
		pulses = 0;
		while (!done && pulses < MAX_PULSES) begin
			gap = 2 + int'(next_rand() % 32'd8);
			repeat (gap) begin
				read_view(VIEW_STATUS, v);
				if (v[STAT_HALTED]) begin
					done = 1'b1;
				end
			end
			if (!done) begin
				len = 1 + int'(next_rand() % 32'd6);
				@(posedge clk);
				hold <= 1'b1;
				sw   <= VIEW_PC;
				@(negedge clk);
				pc_ref  = led_data;
				have_st = 1'b0;
				st_ref  = '0;
				for (int i = 1; i < len; i++) begin
					if (i[0]) begin
						read_view(VIEW_STATUS, v);
						if (!have_st) begin
							st_ref  = v;
							have_st = 1'b1;
						end
						// Booted core is running unless it has halted
						check_status("status during hold", v, 1'b1, 1'b1,
							st_ref[STAT_HALTED], !st_ref[STAT_HALTED]);
					end else begin
						read_view(VIEW_PC, v);
						check_data("led_data pc during hold", v, pc_ref);
					end
				end
				@(posedge clk);
				hold <= 1'b0;
				pulses++;
			end
		end
		wait_halted();
	endtask

	task automatic final_checks();
		logic [LED_W-1:0] v;
		for (int r = 0; r < NUM_REGS; r++) begin
			read_view(reg_view(r), v);
			check_data($sformatf("led_data r%0d final", r), v, model_regs[r]);
		end
		read_view(VIEW_PC, v);
		check_data("led_data pc at halt", v, 16'(prog_len - 1));
		read_view(VIEW_INST, v);
		check_data("led_data inst at halt", v, prog[prog_len - 1]);
	endtask

	function automatic logic is_defined_view(input logic [LED_W-1:0] v);
		case (v)
			VIEW_STATUS, VIEW_INIT_DATA, VIEW_INIT_ADDR, VIEW_PC,
			VIEW_INST, VIEW_ALU_RES, VIEW_WB_RES: return 1'b1;
			default: return (v[15:3] == 13'h0006);
		endcase
	endfunction

	task automatic check_unknown_views();
		logic [LED_W-1:0] code;
		logic [LED_W-1:0] v;
		for (int i = 0; i < 16; i++) begin
			code = LED_W'(next_rand() >> 8);
			// Flipping bit 8 moves any defined code out of the view range
			if (is_defined_view(code)) begin
				code = code ^ 16'h0100;
			end
			read_view(code, v);
			check_data("led_data echo of sw", v, code);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////
	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		boot_done    = 1'b0;
		hold         = 1'b0;
		init_mem_wr  = 1'b0;
		init_addr    = '0;
		init_data    = '0;
		sw           = '0;
		rng          = 32'd72;
		value_errors = 0;
		other_errors = 0;
		apply_reset();
		check_after_reset();
		for (int p = 0; p < NUM_PROGS; p++) begin
			if (p > 0) begin
				apply_reset();
			end
			build_program();
			run_model();
			load_program();
			if (p % 2 == 0) begin
				run_timed();
			end else begin
				run_with_hold();
			end
			final_checks();
		end
		check_unknown_views();
		$display("Checks done: %0d value errors, %0d other errors",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* sim/cpu_top_chk.sv */
module cpu_top_chk import cpu_pkg::*; (
	input logic              clk,
	input logic              reset,
	input logic              hold,
	input logic              wr_en,
	input logic [DATA_W-1:0] pc,
	input ctrl_state_e       state
);

	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////////////////////////
	// Control timing properties
	//////////////////////////////////////////////////////////////////////

	// Frozen core never writes the register file
	no_write_in_hold: assert property (@(posedge clk) disable iff (reset)
		hold |-> !wr_en)
		else $error("register write while hold is high");

	// One write strobe per instruction
	single_cycle_write: assert property (@(posedge clk) disable iff (reset)
		wr_en |=> !wr_en)
		else $error("register write strobe longer than one cycle");

	pc_moves_after_writeback: assert property (@(posedge clk) disable iff (reset)
		!$stable(pc) |-> ($past(state) == WRITEBACK))
		else $error("PC changed outside of WRITEBACK");

	// Only reset leaves HALTED
	halted_is_final: assert property (@(posedge clk) disable iff (reset)
		(state == HALTED) |=> (state == HALTED))
		else $error("state left HALTED without reset");

endmodule

bind core_ctrl cpu_top_chk u_chk (
	.clk   (clk),
	.reset (reset),
	.hold  (hold),
	.wr_en (regs.wr_en),
	.pc    (pc),
	.state (state)
);

/* src/cpu_top.sv */
module cpu_top import cpu_pkg::*, debug_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               boot_done,
	input  logic               hold,
	input  logic               init_mem_wr,
	input  logic [IMEM_AW-1:0] init_addr,
	input  logic [DATA_W-1:0]  init_data,
	input  logic [LED_W-1:0]   sw,
	output logic [LED_W-1:0]   led_data
);

	logic [IMEM_AW-1:0] imem_addr;
	logic [DATA_W-1:0]  imem_data;
	opcode_e            alu_op;
	logic [DATA_W-1:0]  alu_a;
	logic [DATA_W-1:0]  alu_b;
	logic [IMM_W-1:0]   alu_imm;
	logic [SHAMT_W-1:0] alu_shamt;
	logic [DATA_W-1:0]  alu_res;
	logic [DATA_W-1:0]  pc;
	logic [DATA_W-1:0]  inst;
	logic [DATA_W-1:0]  wb_res;
	logic               halted;
	logic               running;
	logic [REG_AW-1:0]  dbg_addr;
	logic [DATA_W-1:0]  dbg_value;

	reg_port_if rp ();

	inst_mem u_imem (
		.clk         (clk),
		.init_mem_wr (init_mem_wr),
		.init_addr   (init_addr),
		.init_data   (init_data),
		.rd_addr     (imem_addr),
		.rd_data     (imem_data)
	);

	reg_file u_regs (
		.clk       (clk),
		.reset     (reset),
		.regs      (rp.regs),
		.dbg_addr  (dbg_addr),
		.dbg_value (dbg_value)
	);

	alu u_alu (
		.op    (alu_op),
		.a     (alu_a),
		.b     (alu_b),
		.imm   (alu_imm),
		.shamt (alu_shamt),
		.res   (alu_res)
	);

	core_ctrl u_ctrl (
		.clk       (clk),
		.reset     (reset),
		.boot_done (boot_done),
		.hold      (hold),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.regs      (rp.ctrl),
		.alu_op    (alu_op),
		.alu_a     (alu_a),
		.alu_b     (alu_b),
		.alu_imm   (alu_imm),
		.alu_shamt (alu_shamt),
		.alu_res   (alu_res),
		.pc        (pc),
		.inst      (inst),
		.wb_res    (wb_res),
		.halted    (halted),
		.running   (running)
	);

	led_ctrl u_led (
		.clk         (clk),
		.reset       (reset),
		.sw          (sw),
		.init_mem_wr (init_mem_wr),
		.init_addr   (init_addr),
		.init_data   (init_data),
		.boot_done   (boot_done),
		.hold        (hold),
		.pc          (pc),
		.inst        (inst),
		.alu_res     (alu_res),
		.wb_res      (wb_res),
		.halted      (halted),
		.running     (running),
		.dbg_addr    (dbg_addr),
		.dbg_value   (dbg_value),
		.led_data    (led_data)
	);

endmodule

/* src/led_ctrl.sv */
module led_ctrl import cpu_pkg::*, debug_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic [LED_W-1:0]   sw,
	input  logic               init_mem_wr,
	input  logic [IMEM_AW-1:0] init_addr,
	input  logic [DATA_W-1:0]  init_data,
	input  logic               boot_done,
	input  logic               hold,
	input  logic [DATA_W-1:0]  pc,
	input  logic [DATA_W-1:0]  inst,
	input  logic [DATA_W-1:0]  alu_res,
	input  logic [DATA_W-1:0]  wb_res,
	input  logic               halted,
	input  logic               running,
	output logic [REG_AW-1:0]  dbg_addr,
	input  logic [DATA_W-1:0]  dbg_value,
	output logic [LED_W-1:0]   led_data
);

	logic [IMEM_AW-1:0] last_init_addr;
	logic [DATA_W-1:0]  last_init_data;
	logic [LED_W-1:0]   status;
	logic               reg_view;

	// Last program word written by the loader
	always_ff @(posedge clk) begin
		if (reset) begin
			last_init_addr <= '0;
			last_init_data <= '0;
		end else if (init_mem_wr) begin
			last_init_addr <= init_addr;
			last_init_data <= init_data;
		end
	end

	always_comb begin
		status              = '0;
		status[STAT_BOOT]   = boot_done;
		status[STAT_HOLD]   = hold;
		status[STAT_HALTED] = halted;
		status[STAT_RUN]    = running;
	end

	//////////////////////////////////////////////////////////////////////
	// View select
	//////////////////////////////////////////////////////////////////////
	assign dbg_addr = sw[REG_AW-1:0];
	assign reg_view = ({sw[LED_W-1:REG_AW], {REG_AW{1'b0}}} == VIEW_REG_BASE);

	always_comb begin
		case (sw)
			VIEW_STATUS:    led_data = status;
			VIEW_INIT_DATA: led_data = last_init_data;
			VIEW_INIT_ADDR: led_data = {{(LED_W-IMEM_AW){1'b0}}, last_init_addr};
			VIEW_PC:        led_data = pc;
			VIEW_INST:      led_data = inst;
			VIEW_ALU_RES:   led_data = alu_res;
			VIEW_WB_RES:    led_data = wb_res;
			// Register views, else echo the switches
			default:        led_data = reg_view ? dbg_value : sw;
		endcase
	end

endmodule

/* src/core_ctrl.sv */
module core_ctrl import cpu_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               boot_done,
	input  logic               hold,
	output logic [IMEM_AW-1:0] imem_addr,
	input  logic [DATA_W-1:0]  imem_data,
	reg_port_if.ctrl           regs,
	output opcode_e            alu_op,
	output logic [DATA_W-1:0]  alu_a,
	output logic [DATA_W-1:0]  alu_b,
	output logic [IMM_W-1:0]   alu_imm,
	output logic [SHAMT_W-1:0] alu_shamt,
	input  logic [DATA_W-1:0]  alu_res,
	output logic [DATA_W-1:0]  pc,
	output logic [DATA_W-1:0]  inst,
	output logic [DATA_W-1:0]  wb_res,
	output logic               halted,
	output logic               running
);

	ctrl_state_e       state;
	opcode_e           op;
	logic              op_writes;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] exe_res;

	// Unknown codes fall through to NOP behaviour
	assign op = opcode_e'(inst[OP_MSB:OP_LSB]);

	always_comb begin
		case (op)
			LI, ADDIU, ADDU, SUBU, AND_OP, OR_OP, SLL: op_writes = 1'b1;
			default:                                    op_writes = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// State machine and datapath registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			pc      <= '0;
			inst    <= '0;
			op_a    <= '0;
			op_b    <= '0;
			exe_res <= '0;
			wb_res  <= '0;
		end else if (!hold) begin
			case (state)
				IDLE: begin
					if (boot_done) begin
						state <= FETCH;
					end
				end
				FETCH: begin
					state <= DECODE;
				end
				DECODE: begin
					inst  <= imem_data;
					op_a  <= regs.rd_data1;
					op_b  <= regs.rd_data2;
					state <= EXECUTE;
				end
				EXECUTE: begin
					exe_res <= alu_res;
					// PC stays on the HALT word
					state <= (op == HALT) ? HALTED : WRITEBACK;
				end
				WRITEBACK: begin
					if (op_writes) begin
						wb_res <= exe_res;
					end
					pc    <= pc + DATA_W'(1);
					state <= FETCH;
				end
				default: begin
					state <= state;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory, register file and ALU hookup
	//////////////////////////////////////////////////////////////////////
	assign imem_addr = pc[IMEM_AW-1:0];

	// Source fields come straight off the memory word during DECODE
	assign regs.rd_addr1 = imem_data[RX_MSB:RX_LSB];
	assign regs.rd_addr2 = imem_data[RY_MSB:RY_LSB];

	// Three-register ops target rz, the rest write back to rx
	always_comb begin
		case (op)
			ADDU, SUBU, AND_OP, OR_OP: regs.wr_addr = inst[RZ_MSB:RZ_LSB];
			default:                   regs.wr_addr = inst[RX_MSB:RX_LSB];
		endcase
	end

	assign regs.wr_en   = (state == WRITEBACK) && !hold && op_writes;
	assign regs.wr_data = exe_res;

	assign alu_op    = op;
	assign alu_a     = op_a;
	assign alu_b     = op_b;
	assign alu_imm   = inst[IMM_W-1:0];
	assign alu_shamt = inst[RZ_MSB:RZ_LSB];

	assign halted  = (state == HALTED);
	assign running = (state != IDLE) && (state != HALTED);

endmodule

/* src/alu.sv */
module alu import cpu_pkg::*; (
	input  opcode_e            op,
	input  logic [DATA_W-1:0]  a,
	input  logic [DATA_W-1:0]  b,
	input  logic [IMM_W-1:0]   imm,
	input  logic [SHAMT_W-1:0] shamt,
	output logic [DATA_W-1:0]  res
);

	logic [DATA_W-1:0]  imm_sext;
	logic [DATA_W-1:0]  imm_zext;
	logic [SHAMT_W:0]   shift;

	assign imm_sext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
	assign imm_zext = {{(DATA_W-IMM_W){1'b0}}, imm};

	// Shift amount of zero encodes a shift by eight
	assign shift = (shamt == '0) ? {1'b1, {SHAMT_W{1'b0}}} : {1'b0, shamt};

	always_comb begin
		case (op)
			LI:      res = imm_zext;
			ADDIU:   res = a + imm_sext;
			ADDU:    res = a + b;
			SUBU:    res = a - b;
			AND_OP:  res = a & b;
			OR_OP:   res = a | b;
			SLL:     res = a << shift;
			default: res = '0;
		endcase
	end

endmodule

/* src/reg_file.sv */
module reg_file import cpu_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	reg_port_if.regs          regs,
	input  logic [REG_AW-1:0] dbg_addr,
	output logic [DATA_W-1:0] dbg_value
);

	logic [DATA_W-1:0] rf [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				rf[i] <= '0;
			end
		end else if (regs.wr_en) begin
			rf[regs.wr_addr] <= regs.wr_data;
		end
	end

	// Reads are plain muxes, no forwarding
	assign regs.rd_data1 = rf[regs.rd_addr1];
	assign regs.rd_data2 = rf[regs.rd_addr2];

	// Debug port for the LED register views
	assign dbg_value = rf[dbg_addr];

endmodule

/* src/inst_mem.sv */
module inst_mem import cpu_pkg::*; (
	input  logic               clk,
	input  logic               init_mem_wr,
	input  logic [IMEM_AW-1:0] init_addr,
	input  logic [DATA_W-1:0]  init_data,
	input  logic [IMEM_AW-1:0] rd_addr,
	output logic [DATA_W-1:0]  rd_data
);

	logic [DATA_W-1:0] mem [IMEM_DEPTH];

	// Program load port
	always_ff @(posedge clk) begin
		if (init_mem_wr) begin
			mem[init_addr] <= init_data;
		end
	end

	// Word addressed in FETCH shows up in DECODE
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* src/reg_port_if.sv */
interface reg_port_if import cpu_pkg::*; ();

	logic [REG_AW-1:0] rd_addr1;
	logic [REG_AW-1:0] rd_addr2;
	logic [DATA_W-1:0] rd_data1;
	logic [DATA_W-1:0] rd_data2;
	logic              wr_en;
	logic [REG_AW-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;

	// Control side drives addresses and write data
	modport ctrl (
		output rd_addr1, rd_addr2, wr_en, wr_addr, wr_data,
		input  rd_data1, rd_data2
	);

	modport regs (
		input  rd_addr1, rd_addr2, wr_en, wr_addr, wr_data,
		output rd_data1, rd_data2
	);

endinterface

/* src/debug_pkg.sv */
package debug_pkg;

	localparam int LED_W = 16;

	//////////////////////////////////////////////////////////////////////
	// Switch codes for the LED views
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [LED_W-1:0] {
		VIEW_STATUS    = 16'h0000,
		VIEW_INIT_DATA = 16'h0003,
		VIEW_INIT_ADDR = 16'h0004,
		VIEW_PC        = 16'h000F,
		VIEW_INST      = 16'h0010,
		VIEW_ALU_RES   = 16'h001B,
		VIEW_WB_RES    = 16'h0020,
		// r0 to r7 sit at the base plus the register index
		VIEW_REG_BASE  = 16'h0030
	} led_view_e;

	// Status word bits, all others read zero
	localparam int STAT_BOOT   = 15;
	localparam int STAT_HOLD   = 13;
	localparam int STAT_HALTED = 11;
	localparam int STAT_RUN    = 9;

endpackage

/* src/cpu_pkg.sv */
package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data and address widths
	//////////////////////////////////////////////////////////////////////
	localparam int DATA_W     = 16;
	localparam int REG_AW     = 3;
	localparam int NUM_REGS   = 1 << REG_AW;
	localparam int IMEM_AW    = 8;
	localparam int IMEM_DEPTH = 1 << IMEM_AW;

	// Instruction field positions
	localparam int OP_W    = 5;
	localparam int OP_MSB  = 15;
	localparam int OP_LSB  = 11;
	localparam int RX_MSB  = 10;
	localparam int RX_LSB  = 8;
	localparam int RY_MSB  = 7;
	localparam int RY_LSB  = 5;
	localparam int RZ_MSB  = 4;
	localparam int RZ_LSB  = 2;
	localparam int IMM_W   = 8;
	localparam int SHAMT_W = 3;

	// Any code not listed decodes as NOP
	typedef enum logic [OP_W-1:0] {
		NOP    = 5'b00001,
		SLL    = 5'b00110,
		ADDIU  = 5'b01001,
		LI     = 5'b01101,
		OR_OP  = 5'b11001,
		AND_OP = 5'b11010,
		SUBU   = 5'b11011,
		ADDU   = 5'b11100,
		HALT   = 5'b11111
	} opcode_e;

	// One instruction walks FETCH to WRITEBACK
	typedef enum logic [2:0] {
		IDLE, FETCH, DECODE, EXECUTE, WRITEBACK, HALTED
	} ctrl_state_e;

endpackage
